/* verilog.f */
+incdir+include
verilog/uart_pkg.sv
verilog/uart_fifo.sv
verilog/uart_transmitter.sv
verilog/uart_receiver.sv
verilog/uart_controller.sv
sim/uart_line_model.sv
sim/uart_controller_tb.sv

/* sim/uart_tests.txt */
# Columns: command letter, test name, byte count, then that many hex bytes.
# T transmit, R receive, E empty read, F framing error (bad byte, good byte), O overflow.
T tx_single 1 a5
T tx_pair 2 00 ff
T tx_walk_one 8 01 02 04 08 10 20 40 80
T tx_alternate 4 55 aa 55 aa
T tx_full_fifo 16 10 32 54 76 98 ba dc fe 01 23 45 67 89 ab cd ef
R rx_single 1 3c
R rx_pair 2 55 aa
R rx_walk_zero 8 fe fd fb f7 ef df bf 7f
R rx_edges 3 00 ff 81
R rx_full_fifo 16 3d 7a f4 e9 d3 a7 4f 9e 3c 78 f0 e1 c3 87 0f 1e
E empty_after_byte 1 96
E empty_after_zero 1 00
E empty_after_ones 1 ff
F frame_low_stop 2 00 c3
F frame_bad_ones 2 ff 5a
F frame_bad_mixed 2 a7 01
# Overflow lines carry 20 bytes; the first 17 also feed the receive side.
O overflow_count 20 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13
O overflow_mixed 20 e1 37 9c 4d 00 ff 62 b8 15 ca 7e 23 d9 84 5f a6 3b f0 c7 18

/* sim/uart_controller_tb.sv */
`include "uart_cfg.svh"

module uart_controller_tb import uart_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int   FRAME_CLKS  = 10 * `UART_CLKS_PER_BIT + 8; // With feeder slack.
    localparam logic ADDR_STATUS = 1'b0;
    localparam logic ADDR_DATA   = 1'b1;

    logic  clk = 1'b0;
    logic  rst;
    logic  bus_write;
    logic  bus_read;
    logic  bus_address;
    word_t bus_wdata;
    word_t bus_rdata;
    logic  irq;
    logic  txd;
    logic  rxd;

    string test_name;
    byte_t bytes[$];
    int    test_errors;
    int    pass_count;
    int    fail_count;

    always #50 clk = ~clk;

    uart_controller uart_controller_inst (
        .clk,
        .rst,
        .bus_write,
        .bus_read,
        .bus_address,
        .bus_wdata,
        .bus_rdata,
        .irq,
        .txd,
        .rxd
    );

    uart_line_model uart_line_model_inst (
        .clk,
        .txd,
        .rxd
    );

    ////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////

    task automatic report_mismatch(input word_t expected, input word_t actual);
        $display("[FAIL] %0s: expected %h, actual %h", test_name, expected, actual);
        test_errors++;
    endtask

    task automatic report_problem(input string what);
        $display("Error in %0s: %0s", test_name, what);
        test_errors++;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            pass_count++;
            $display("test %0s passed", test_name);
        end else begin
            fail_count++;
            $display("test %0s failed with %0d errors", test_name, test_errors);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Bus access and waits
    ////////////////////////////////////////////////////////////

    task automatic idle_gap();
        repeat ($urandom % 4) @(posedge clk);
    endtask

    task automatic write_word(input logic address, input word_t data);
        @(posedge clk);
        bus_write   <= 1'b1;
        bus_address <= address;
        bus_wdata   <= data;
        @(posedge clk);
        bus_write <= 1'b0;
    endtask

    // The word is taken half a clock after the DUT loads it.
    task automatic read_word(input logic address, output word_t data);
        @(posedge clk);
        bus_read    <= 1'b1;
        bus_address <= address;
        @(posedge clk);
        bus_read <= 1'b0;
        @(negedge clk);
        data = bus_rdata;
    endtask

    task automatic wait_for_irq(input int limit);
        int cycles;
        cycles = 0;
        while (irq !== 1'b1 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (irq !== 1'b1) report_problem("timed out waiting for irq to rise");
    endtask

    task automatic wait_for_tx(input int count, input int limit);
        int cycles;
        cycles = 0;
        while (uart_line_model_inst.tx_count() < count && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (uart_line_model_inst.tx_count() < count) begin
            report_problem("timed out waiting for frames on txd");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test kinds
    ////////////////////////////////////////////////////////////

    task automatic run_transmit();
        word_t value;
        uart_line_model_inst.clear_tx();
        foreach (bytes[i]) begin
            write_word(ADDR_DATA, {24'h0, bytes[i]});
            idle_gap();
        end
        wait_for_tx(bytes.size(), (bytes.size() + 2) * FRAME_CLKS);
        foreach (bytes[i]) begin
            if (i < uart_line_model_inst.tx_count()) begin
                if (uart_line_model_inst.tx_byte(i) !== bytes[i]) begin
                    report_mismatch(bytes[i], uart_line_model_inst.tx_byte(i));
                end
            end
        end
        if (uart_line_model_inst.bad_stop_count() != 0) begin
            report_problem("a frame on txd had a low stop bit");
        end
        read_word(ADDR_STATUS, value);
        if (value[0] !== 1'b1) report_mismatch(32'h1, word_t'(value[0]));
    endtask

    task automatic run_receive();
        word_t value;
        foreach (bytes[i]) begin
            uart_line_model_inst.send_frame(bytes[i], 1'b0);
        end
        wait_for_irq(2 * FRAME_CLKS);
        read_word(ADDR_STATUS, value);
        if (value[1] !== 1'b1) report_mismatch(32'h1, word_t'(value[1]));
        foreach (bytes[i]) begin
            idle_gap();
            read_word(ADDR_DATA, value);
            if (value !== {24'h0, bytes[i]}) report_mismatch({24'h0, bytes[i]}, value);
        end
        if (irq !== 1'b0) report_mismatch(32'h0, word_t'(irq));
        read_word(ADDR_STATUS, value);
        if (value[1] !== 1'b0) report_mismatch(32'h0, word_t'(value[1]));
    endtask

    task automatic run_empty_read();
        word_t first;
        word_t second;
        uart_line_model_inst.send_frame(bytes[0], 1'b0);
        wait_for_irq(2 * FRAME_CLKS);
        read_word(ADDR_DATA, first);
        if (first !== {24'h0, bytes[0]}) report_mismatch({24'h0, bytes[0]}, first);
        read_word(ADDR_DATA, second); // FIFO is empty now.
        if (second !== {24'h0, bytes[0]}) report_mismatch({24'h0, bytes[0]}, second);
    endtask

    task automatic run_framing();
        word_t value;
        uart_line_model_inst.send_frame(bytes[0], 1'b1);
        uart_line_model_inst.send_frame(bytes[1], 1'b0);
        wait_for_irq(2 * FRAME_CLKS);
        read_word(ADDR_DATA, value);
        if (value !== {24'h0, bytes[1]}) report_mismatch({24'h0, bytes[1]}, value);
        read_word(ADDR_STATUS, value);
        if (value[1] !== 1'b0) report_mismatch(32'h0, word_t'(value[1]));
    endtask

    task automatic run_overflow();
        word_t value;
        int    i;
        int    next;
        // One frame more than the receive FIFO holds.
        for (i = 0; i < 17; i++) begin
            uart_line_model_inst.send_frame(bytes[i], 1'b0);
        end
        wait_for_irq(2 * FRAME_CLKS);
        for (i = 0; i < 16; i++) begin
            read_word(ADDR_DATA, value);
            if (value !== {24'h0, bytes[i]}) report_mismatch({24'h0, bytes[i]}, value);
        end
        if (irq !== 1'b0) report_mismatch(32'h0, word_t'(irq));
        // The transmit FIFO plus the byte in flight get through.
        uart_line_model_inst.clear_tx();
        for (i = 0; i < 20; i++) begin
            write_word(ADDR_DATA, {24'h0, bytes[i]});
        end
        wait_for_tx(17, 20 * FRAME_CLKS);
        repeat (2 * FRAME_CLKS) @(negedge clk); // Time for any late frame.
        for (i = 0; i < 17 && i < uart_line_model_inst.tx_count(); i++) begin
            if (uart_line_model_inst.tx_byte(i) !== bytes[i]) begin
                report_mismatch(bytes[i], uart_line_model_inst.tx_byte(i));
            end
        end
        next = 17;
        for (i = 17; i < uart_line_model_inst.tx_count(); i++) begin
            while (next < 20 && bytes[next] !== uart_line_model_inst.tx_byte(i)) begin
                next++;
            end
            if (next >= 20) report_problem("a frame on txd is out of write order");
            next++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int               fd;
        int               c;
        int               count;
        int               scan;
        int               seed;
        int               i;
        logic [7:0]       cmd;
        logic [31:0]      field;
        logic [8*256-1:0] skipped;
        word_t            value;

        seed        = $urandom(32'h2daa2bdf);
        rst         = 1'b1;
        bus_write   = 1'b0;
        bus_read    = 1'b0;
        bus_address = 1'b0;
        bus_wdata   = '0;
        pass_count  = 0;
        fail_count  = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        test_name   = "reset_state";
        test_errors = 0;
        @(negedge clk);
        if (txd !== 1'b1) report_mismatch(32'h1, word_t'(txd));
        if (irq !== 1'b0) report_mismatch(32'h0, word_t'(irq));
        if (bus_rdata !== 32'h0) report_mismatch(32'h0, bus_rdata);
        read_word(ADDR_STATUS, value);
        if (value !== 32'h1) report_mismatch(32'h1, value);
        finish_test();

        fd = $fopen("sim/uart_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file sim/uart_tests.txt");
            fail_count++;
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == "#") begin
                    scan = $fgets(skipped, fd);
                end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
                    cmd = c[7:0];
                    scan = $fscanf(fd, "%s %d", test_name, count);
                    bytes.delete();
                    for (i = 0; i < count; i++) begin
                        scan = $fscanf(fd, "%h", field);
                        bytes.push_back(field[7:0]);
                    end
                    test_errors = 0;
                    case (cmd)
                        "T": run_transmit();
                        "R": run_receive();
                        "E": run_empty_read();
                        "F": run_framing();
                        "O": run_overflow();
                        default: report_problem("unknown command letter in the data file");
                    endcase
                    finish_test();
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end

        $display("Tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sim/uart_line_model.sv */
`include "uart_cfg.svh"

module uart_line_model import uart_pkg::*; (
    input  logic clk,
    input  logic txd,
    output logic rxd
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLKS_PER_BIT = `UART_CLKS_PER_BIT;

    byte_t tx_bytes[$];
    byte_t frame_data;
    int    stop_errors = 0;
    int    bit_pos;

    initial begin
        rxd = 1'b1; // Line idles high.
    end

    ////////////////////////////////////////////////////////////
    // Serial drive towards the DUT
    ////////////////////////////////////////////////////////////

    task automatic drive_bit(input logic level);
        @(posedge clk);
        rxd <= level;
        repeat (CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    // One 8N1 frame, then one idle bit time.
    task automatic send_frame(input byte_t data, input logic low_stop);
        int i;
        drive_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        drive_bit(!low_stop);
        drive_bit(1'b1);
    endtask

    ////////////////////////////////////////////////////////////
    // txd monitor
    ////////////////////////////////////////////////////////////

    always begin
        @(posedge clk);
        if (txd === 1'b0) begin
            repeat (CLKS_PER_BIT / 2) @(posedge clk); // Middle of the start bit.
            if (txd === 1'b0) begin
                for (bit_pos = 0; bit_pos < 8; bit_pos++) begin
                    repeat (CLKS_PER_BIT) @(posedge clk);
                    frame_data[bit_pos] = txd;
                end
                repeat (CLKS_PER_BIT) @(posedge clk);
                if (txd !== 1'b1) begin
                    stop_errors++;
                end
                tx_bytes.push_back(frame_data);
            end
        end
    end

    function void clear_tx();
        tx_bytes.delete();
        stop_errors = 0;
    endfunction

    function int tx_count();
        return tx_bytes.size();
    endfunction

    function byte_t tx_byte(input int index);
        return tx_bytes[index];
    endfunction

    function int bad_stop_count();
        return stop_errors;
    endfunction

endmodule

/* verilog/uart_controller.sv */
`include "uart_cfg.svh"

module uart_controller import uart_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  bus_write,
    input  logic  bus_read,
    input  logic  bus_address,
    input  word_t bus_wdata,
    output word_t bus_rdata,
    output logic  irq,
    output logic  txd,
    input  logic  rxd
);

    localparam logic ADDR_STATUS = 1'b0;
    localparam logic ADDR_DATA   = 1'b1;

    logic           tx_fifo_write;
    logic           tx_fifo_read;
    logic           tx_fifo_full;
    logic           tx_fifo_empty;
    byte_t          tx_fifo_dout;
    logic           tx_start;
    logic           tx_busy;
    tx_feed_state_t feed_state;

    logic           rx_fifo_read;
    logic           rx_fifo_empty;
    byte_t          rx_fifo_dout;
    byte_t          rx_data;
    logic           rx_valid;

    ////////////////////////////////////////////////////////////
    // Transmit path
    ////////////////////////////////////////////////////////////

    // Writes to a full FIFO are lost.
    assign tx_fifo_write = bus_write && (bus_address == ADDR_DATA) && !tx_fifo_full;

    uart_fifo #(
        .DEPTH_LOG2(`UART_TX_DEPTH_LOG2)
    ) tx_fifo_inst (
        .clk,
        .rst,
        .din(bus_wdata[7:0]),
        .wr_en(tx_fifo_write),
        .rd_en(tx_fifo_read),
        .dout(tx_fifo_dout),
        .full(tx_fifo_full),
        .empty(tx_fifo_empty)
    );

    // Head byte is latched by the transmitter on the same edge it is popped.
    assign tx_start     = (feed_state == FEED_IDLE) && !tx_fifo_empty;
    assign tx_fifo_read = tx_start;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            feed_state <= FEED_IDLE;
        end else begin
            case (feed_state)
                FEED_IDLE: begin
                    if (!tx_fifo_empty) begin
                        feed_state <= FEED_SEND;
                    end
                end
                FEED_SEND: begin
                    feed_state <= FEED_WAIT; // Busy is up by now.
                end
                FEED_WAIT: begin
                    if (!tx_busy) begin
                        feed_state <= FEED_IDLE;
                    end
                end
                default: begin
                    feed_state <= FEED_IDLE;
                end
            endcase
        end
    end

    uart_transmitter uart_transmitter_inst (
        .clk,
        .rst,
        .tx_start,
        .tx_data(tx_fifo_dout),
        .txd,
        .tx_busy
    );

    ////////////////////////////////////////////////////////////
    // Receive path
    ////////////////////////////////////////////////////////////

    uart_receiver uart_receiver_inst (
        .clk,
        .rst,
        .rxd,
        .rx_data,
        .rx_valid
    );

    // A byte arriving while full is dropped inside the FIFO.
    uart_fifo #(
        .DEPTH_LOG2(`UART_RX_DEPTH_LOG2)
    ) rx_fifo_inst (
        .clk,
        .rst,
        .din(rx_data),
        .wr_en(rx_valid),
        .rd_en(rx_fifo_read),
        .dout(rx_fifo_dout),
        .full(),
        .empty(rx_fifo_empty)
    );

    assign irq = !rx_fifo_empty; // Data waiting.

    ////////////////////////////////////////////////////////////
    // Bus read
    ////////////////////////////////////////////////////////////

    assign rx_fifo_read = bus_read && (bus_address == ADDR_DATA) && !rx_fifo_empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus_rdata <= '0;
        end else if (bus_read && bus_address == ADDR_STATUS) begin
            bus_rdata <= {30'b0, !rx_fifo_empty, !tx_fifo_full};
        end else if (rx_fifo_read) begin
            bus_rdata <= word_t'(rx_fifo_dout);
        end
    end

endmodule

/* verilog/uart_receiver.sv */
`include "uart_cfg.svh"

module uart_receiver import uart_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  rxd,
    output byte_t rx_data,
    output logic  rx_valid
);

    localparam baud_count_t HALF_LAST = baud_count_t'(`UART_CLKS_PER_BIT / 2 - 1);
    localparam baud_count_t BIT_LAST  = baud_count_t'(`UART_CLKS_PER_BIT - 1);
    localparam bit_count_t  LAST_DATA_BIT = bit_count_t'(7);

    // Ends one clock before the stop bit does, so a
    // back-to-back start bit is caught on time.
    localparam baud_count_t STOP_LAST =
        baud_count_t'(`UART_CLKS_PER_BIT + `UART_CLKS_PER_BIT / 2 - 2);

    rx_state_t   state;
    baud_count_t baud_count;
    bit_count_t  bit_index;
    logic        rxd_meta;
    logic        rxd_sync;
    logic        stop_ok;
    logic        sample_data;

    assign sample_data = (state == RX_DATA) && (baud_count == BIT_LAST);

    ////////////////////////////////////////////////////////////
    // Input synchronizer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rxd_meta <= 1'b1; // Line idles high.
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    // LSB arrives first and ends up at bit 0.
    always_ff @(posedge clk) begin
        if (sample_data) begin
            rx_data <= {rxd_sync, rx_data[7:1]};
        end
    end

    ////////////////////////////////////////////////////////////
    // Frame sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= RX_IDLE;
            baud_count <= '0;
            bit_index  <= '0;
            stop_ok    <= 1'b0;
            rx_valid   <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    baud_count <= '0;
                    // The line was high, so a low here is the falling edge.
                    if (!rxd_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (baud_count == HALF_LAST) begin
                        baud_count <= '0;
                        bit_index  <= '0;
                        state      <= rxd_sync ? RX_IDLE : RX_DATA; // Glitch check.
                    end else begin
                        baud_count <= baud_count + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (baud_count == BIT_LAST) begin
                        baud_count <= '0;
                        if (bit_index == LAST_DATA_BIT) begin
                            state <= RX_STOP;
                        end else begin
                            bit_index <= bit_index + 1'b1;
                        end
                    end else begin
                        baud_count <= baud_count + 1'b1;
                    end
                end
                RX_STOP: begin
                    baud_count <= baud_count + 1'b1;
                    if (baud_count == BIT_LAST) begin
                        stop_ok <= rxd_sync; // Middle of the stop bit.
                    end
                    if (baud_count == STOP_LAST) begin
                        baud_count <= '0;
                        rx_valid   <= stop_ok; // Framing errors are dropped.
                        state      <= RX_IDLE;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

endmodule

/* verilog/uart_transmitter.sv */
`include "uart_cfg.svh"

module uart_transmitter import uart_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  tx_start,
    input  byte_t tx_data,
    output logic  txd,
    output logic  tx_busy
);

    localparam baud_count_t BIT_LAST = baud_count_t'(`UART_CLKS_PER_BIT - 1);
    localparam bit_count_t  LAST_DATA_BIT = bit_count_t'(7);

    tx_state_t   state;
    baud_count_t baud_count;
    bit_count_t  bit_index;
    byte_t       shift_reg;
    logic        bit_done;

    assign bit_done = (baud_count == BIT_LAST);
    assign tx_busy  = (state != TX_IDLE); // High until the stop bit ends.

    // Low bit is always the next one out.
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_start) begin
            shift_reg <= tx_data;
        end else if (state != TX_IDLE && bit_done) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Frame sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= TX_IDLE;
            baud_count <= '0;
            bit_index  <= '0;
            txd        <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    baud_count <= '0;
                    if (tx_start) begin
                        state <= TX_START;
                        txd   <= 1'b0; // Start bit.
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        baud_count <= '0;
                        bit_index  <= '0;
                        txd        <= shift_reg[0];
                        state      <= TX_DATA;
                    end else begin
                        baud_count <= baud_count + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        baud_count <= '0;
                        if (bit_index == LAST_DATA_BIT) begin
                            txd   <= 1'b1; // Stop bit.
                            state <= TX_STOP;
                        end else begin
                            bit_index <= bit_index + 1'b1;
                            txd       <= shift_reg[0];
                        end
                    end else begin
                        baud_count <= baud_count + 1'b1;
                    end
                end
                TX_STOP: begin
                    if (bit_done) begin
                        baud_count <= '0;
                        state      <= TX_IDLE;
                    end else begin
                        baud_count <= baud_count + 1'b1;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

endmodule

/* verilog/uart_fifo.sv */
module uart_fifo import uart_pkg::*; #(
    parameter int DEPTH_LOG2 = 4
) (
    input  logic  clk,
    input  logic  rst,
    input  byte_t din,
    input  logic  wr_en,
    input  logic  rd_en,
    output byte_t dout,
    output logic  full,
    output logic  empty
);

    localparam int DEPTH = 2 ** DEPTH_LOG2;

    // Pointers carry one extra wrap bit.
    typedef logic [DEPTH_LOG2:0]   ptr_t;
    typedef logic [DEPTH_LOG2-1:0] addr_t;

    byte_t mem [DEPTH];
    ptr_t  wr_ptr;
    ptr_t  rd_ptr;
    addr_t wr_addr;
    addr_t rd_addr;
    logic  do_write;
    logic  do_read;

    assign wr_addr = wr_ptr[DEPTH_LOG2-1:0];
    assign rd_addr = rd_ptr[DEPTH_LOG2-1:0];

    // Same slot, different lap means full.
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_addr == rd_addr) && (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]);

    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    // Show-ahead output.
    assign dout = mem[rd_addr];

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_addr] <= din;
        end
    end

    ////////////////////////////////////////////////////////////
    // Pointers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

/* verilog/uart_pkg.sv */
package uart_pkg;

    ////////////////////////////////////////////////////////////
    // Data widths
    ////////////////////////////////////////////////////////////

    typedef logic [7:0]  byte_t;       // Serial payload.
    typedef logic [31:0] word_t;       // Host bus word.
    typedef logic [3:0]  bit_count_t;  // Bit position inside a frame.
    typedef logic [15:0] baud_count_t; // Clocks inside one bit.

    ////////////////////////////////////////////////////////////
    // State machines
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        FEED_IDLE,
        FEED_SEND,
        FEED_WAIT
    } tx_feed_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

/* include/uart_cfg.svh */
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

////////////////////////////////////////////////////////////
// Clock and line rate
////////////////////////////////////////////////////////////

`define UART_CLK_FREQ_HZ 10000000
`define UART_BAUD 625000

// Sixteen whole clocks in one bit time.
`define UART_CLKS_PER_BIT (`UART_CLK_FREQ_HZ / `UART_BAUD)

////////////////////////////////////////////////////////////
// Buffering
////////////////////////////////////////////////////////////

`define UART_TX_DEPTH_LOG2 4 // 16 entries.
`define UART_RX_DEPTH_LOG2 4 // 16 entries.

`endif
